// ==== design/link_tx_macros.svh ====
`ifndef LINK_TX_MACROS_SVH
`define LINK_TX_MACROS_SVH

// lane count
`define LINK_LANES      4

// phase lengths in word periods
`define INIT_LEN        64
`define ADJUST_LEN      256
`define ALIGN_LEN       4
`define DATA_LEN        1024

// windows on the down-counter, both bounds exclusive
`define PAT_LO          32
`define PAT_HI          224
`define PHY_LO          64
`define PHY_HI          196

`define ADJUST_PATTERN  32'h0000AAAA
`define ALIGN_CODE      16'hF731

`define LFSR_TAPS       32'h80200003   // x^32+x^22+x^2+x+1, galois form
`define LFSR_SEED_BASE  32'h5EED0001

`endif

// ==== design/link_tx_pkg.sv ====
`default_nettype none

package link_tx_pkg;

  // ####################################################################
  // phases of the training sequence
  // ####################################################################
  typedef enum logic [1:0] {
    INIT          = 2'd0,
    DELAY_ADJUST  = 2'd1,
    WORD_ALIGN    = 2'd2,
    DATA_TRANSFER = 2'd3
  } link_phase_e;

  // ####################################################################
  // lane word views
  // ####################################################################
  typedef struct packed {
    logic [15:0] code;
    logic [7:0]  lane;
    logic [7:0]  round;   // low byte
  } align_word_s;

  // same 32 bits seen raw or as align fields
  typedef union packed {
    logic [31:0] raw;
    align_word_s align;
  } lane_word_u;

endpackage

`default_nettype wire

// ==== design/train_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface train_if;
  import link_tx_pkg::*;

  link_phase_e phase;
  logic [9:0]  cnt;       // period down-counter
  logic        step;      // descriptor valid
  logic        phy_win;
  logic [7:0]  round;
  logic        clr;       // unregistered CLR

  modport seq (output phase, cnt, step, phy_win, round, clr);

  modport lane (input phase, cnt, step, round, clr);

  // output stage only needs timing and phase
  modport mon (input step, phase, phy_win, clr);

endinterface

`default_nettype wire

// ==== design/train_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "link_tx_macros.svh"

module train_sequencer (
  input  logic CLK,
  input  logic RSTX,
  input  logic pull,
  input  logic clr_in,
  train_if.seq tif
);
  import link_tx_pkg::*;

  link_phase_e phase_q;
  logic [9:0]  cnt_q;
  logic [7:0]  round_q;
  logic        phy_hit;

  assign tif.clr = clr_in;  // all stages clear on the same edge

  assign phy_hit = (phase_q == DELAY_ADJUST)
                && (cnt_q > `PHY_LO) && (cnt_q < `PHY_HI);

  // ####################################################################
  // phase and period counter
  // ####################################################################
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      phase_q <= INIT;
      cnt_q   <= 10'(`INIT_LEN - 1);
      round_q <= '0;
    end else if (clr_in) begin
      phase_q <= INIT;
      cnt_q   <= 10'(`INIT_LEN - 1);
      round_q <= '0;
    end else if (pull) begin
      if (cnt_q == '0) begin
        case (phase_q)
          DELAY_ADJUST: begin
            phase_q <= WORD_ALIGN;
            cnt_q   <= 10'(`ALIGN_LEN - 1);
          end
          WORD_ALIGN: begin
            phase_q <= DATA_TRANSFER;
            cnt_q   <= 10'(`DATA_LEN - 1);
          end
          default: begin  // INIT or end of data
            phase_q <= DELAY_ADJUST;
            cnt_q   <= 10'(`ADJUST_LEN - 1);
            round_q <= round_q + 8'd1;
          end
        endcase
      end else begin
        cnt_q <= cnt_q - 10'd1;
      end
    end
  end

  // descriptor of the period just pulled
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      tif.step    <= 1'b0;
      tif.phase   <= INIT;
      tif.cnt     <= '0;
      tif.phy_win <= 1'b0;
      tif.round   <= '0;
    end else if (clr_in) begin
      tif.step    <= 1'b0;
      tif.phase   <= INIT;
      tif.cnt     <= '0;
      tif.phy_win <= 1'b0;
      tif.round   <= '0;
    end else begin
      tif.step <= pull;
      if (pull) begin
        tif.phase   <= phase_q;
        tif.cnt     <= cnt_q;
        tif.phy_win <= phy_hit;
        tif.round   <= round_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/lane_sender.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "link_tx_macros.svh"

module lane_sender #(
  parameter int LANE = 0
) (
  input  logic                   CLK,
  input  logic                   RSTX,
  train_if.lane                  tif,
  output link_tx_pkg::lane_word_u word
);
  import link_tx_pkg::*;

  localparam logic [31:0] SEED = `LFSR_SEED_BASE + LANE;

  logic [31:0] lfsr;
  logic [31:0] lfsr_next;
  logic        in_pat;

  // galois step, shift right
  assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? `LFSR_TAPS : 32'h0);

  assign in_pat = (tif.cnt > `PAT_LO) && (tif.cnt < `PAT_HI);

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      word <= '0;
      lfsr <= SEED;
    end else if (tif.clr) begin
      word <= '0;
      lfsr <= SEED;
    end else if (tif.step) begin
      case (tif.phase)
        DELAY_ADJUST: word.raw <= in_pat ? `ADJUST_PATTERN : 32'h0;
        WORD_ALIGN: begin
          word.align.code  <= `ALIGN_CODE;
          word.align.lane  <= 8'(LANE);
          word.align.round <= tif.round;
        end
        DATA_TRANSFER: begin
          word.raw <= lfsr;
          lfsr     <= lfsr_next;   // runs on across rounds
        end
        default: word <= '0;  // idle INIT
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/link_out_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "link_tx_macros.svh"

module link_out_stage (
  input  logic                           CLK,
  input  logic                           RSTX,
  train_if.mon                           tif,
  input  link_tx_pkg::lane_word_u        lane_words [`LINK_LANES],
  output logic                           DOPUSH,
  output logic                           PHY_INIT,
  output logic [`LINK_LANES*32-1:0]      DOUT,
  output logic [31:0]                    DATA_WORDS,
  output logic [15:0]                    ROUNDS
);
  import link_tx_pkg::*;

  logic                        step_d;
  link_phase_e                 phase_d;
  link_phase_e                 last_phase;  // phase of previous pushed period
  logic                        phy_d;
  logic                        first_adj;
  logic [`LINK_LANES*32-1:0]   dout_next;

  always_comb begin
    for (int i = 0; i < `LINK_LANES; i++) begin
      dout_next[32*i +: 32] = lane_words[i].raw;  // lane 0 lowest
    end
  end

  assign first_adj = (phase_d == DELAY_ADJUST) && (last_phase != DELAY_ADJUST);

  // ####################################################################
  // one cycle behind the lanes
  // ####################################################################
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      step_d     <= 1'b0;
      phase_d    <= INIT;
      phy_d      <= 1'b0;
      last_phase <= INIT;
      DOPUSH     <= 1'b0;
      PHY_INIT   <= 1'b0;
      DOUT       <= '0;
      DATA_WORDS <= '0;
      ROUNDS     <= '0;
    end else if (tif.clr) begin
      step_d     <= 1'b0;
      phase_d    <= INIT;
      phy_d      <= 1'b0;
      last_phase <= INIT;
      DOPUSH     <= 1'b0;
      PHY_INIT   <= 1'b0;
      DOUT       <= '0;
      DATA_WORDS <= '0;
      ROUNDS     <= '0;
    end else begin
      step_d   <= tif.step;
      phase_d  <= tif.phase;
      phy_d    <= tif.phy_win;
      DOPUSH   <= step_d && (phase_d != INIT);
      PHY_INIT <= step_d && phy_d;
      if (step_d) begin
        DOUT       <= dout_next;
        last_phase <= phase_d;
        if (phase_d == DATA_TRANSFER) DATA_WORDS <= DATA_WORDS + 32'd1;
        if (first_adj)                ROUNDS     <= ROUNDS + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/link_tx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "link_tx_macros.svh"

module link_tx_top (
  input  logic                      CLK,
  input  logic                      RSTX,
  input  logic                      DOPULL,
  input  logic                      CLR,
  output logic                      DOPUSH,
  output logic                      PHY_INIT,
  output logic [`LINK_LANES*32-1:0] DOUT,
  output logic [31:0]               DATA_WORDS,
  output logic [15:0]               ROUNDS
);
  import link_tx_pkg::*;

  lane_word_u lane_words [`LINK_LANES];

  train_if tif ();

  train_sequencer i_seq (
    .CLK    (CLK),
    .RSTX   (RSTX),
    .pull   (DOPULL),
    .clr_in (CLR),
    .tif    (tif.seq)
  );

  // one sender per lane
  for (genvar g = 0; g < `LINK_LANES; g++) begin : g_lane
    lane_sender #(.LANE(g)) i_lane (
      .CLK  (CLK),
      .RSTX (RSTX),
      .tif  (tif.lane),
      .word (lane_words[g])
    );
  end

  link_out_stage i_out (
    .CLK        (CLK),
    .RSTX       (RSTX),
    .tif        (tif.mon),
    .lane_words (lane_words),
    .DOPUSH     (DOPUSH),
    .PHY_INIT   (PHY_INIT),
    .DOUT       (DOUT),
    .DATA_WORDS (DATA_WORDS),
    .ROUNDS     (ROUNDS)
  );

endmodule

`default_nettype wire

// ==== tb/tb_link_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "link_tx_macros.svh"

module tb_link_tx;
  import link_tx_pkg::*;

  localparam int LANES = `LINK_LANES;
  localparam int NROWS = 8;

  typedef struct packed {
    logic [15:0] cycles;
    logic [7:0]  pct;      // pull probability in percent
    logic        clr;      // CLR pulse at row start
  } row_t;

  // one pulled period on its way to the outputs
  typedef struct packed {
    logic                  valid;
    link_phase_e           phase;
    logic [9:0]            cnt;
    logic                  phy;
    logic [LANES*32-1:0]   words;
  } rec_t;

  row_t rows [NROWS] = '{
    '{16'd200,  8'd100, 1'b0},   // init into first adjust
    '{16'd1500, 8'd100, 1'b0},
    '{16'd2000, 8'd60,  1'b0},
    '{16'd300,  8'd30,  1'b0},
    '{16'd50,   8'd0,   1'b0},   // frozen
    '{16'd900,  8'd100, 1'b1},   // clr somewhere in round 3
    '{16'd1500, 8'd75,  1'b0},
    '{16'd400,  8'd50,  1'b1}
  };

  logic                CLK;
  logic                RSTX;
  logic                DOPULL;
  logic                CLR;
  logic                DOPUSH;
  logic                PHY_INIT;
  logic [LANES*32-1:0] DOUT;
  logic [31:0]         DATA_WORDS;
  logic [15:0]         ROUNDS;

  // reference model state
  link_phase_e         m_phase;
  logic [9:0]          m_cnt;
  logic [7:0]          m_round;
  logic [31:0]         m_lfsr [LANES];
  rec_t                r1;
  rec_t                r2;
  logic                e_push;
  logic                e_phy;
  logic [LANES*32-1:0] e_dout;
  logic [31:0]         e_data;
  logic [15:0]         e_rounds;
  logic [31:0]         rng;

  link_tx_top i_dut (
    .CLK        (CLK),
    .RSTX       (RSTX),
    .DOPULL     (DOPULL),
    .CLR        (CLR),
    .DOPUSH     (DOPUSH),
    .PHY_INIT   (PHY_INIT),
    .DOUT       (DOUT),
    .DATA_WORDS (DATA_WORDS),
    .ROUNDS     (ROUNDS)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // galois lfsr, right shift, taps folded in when the lsb drops out
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ `LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic int table_cycles();
    int sum;
    sum = 0;
    for (int i = 0; i < NROWS; i++) sum += rows[i].cycles;
    return sum;
  endfunction

  // ####################################################################
  // checks
  // ####################################################################
  task automatic check_word(input int lane, input lane_word_u got, input lane_word_u exp);
    if (got !== exp) begin
      $display("error: DOUT lane %0d got %h expected %h", lane, got.raw, exp.raw);
      $display("sim failed");
      $fatal(1, "lane word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "output bit mismatch");
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "counter mismatch");
    end
  endtask

  task automatic check_outputs();
    check_bit("DOPUSH", DOPUSH, e_push);
    check_bit("PHY_INIT", PHY_INIT, e_phy);
    for (int i = 0; i < LANES; i++) begin
      check_word(i, DOUT[32*i +: 32], e_dout[32*i +: 32]);
    end
    check_count("DATA_WORDS", DATA_WORDS, e_data);
    check_count("ROUNDS", ROUNDS, e_rounds);
  endtask

  // ####################################################################
  // reference model, one call per rising edge
  // ####################################################################
  task automatic model_clear();
    m_phase  = INIT;
    m_cnt    = 10'(`INIT_LEN - 1);
    m_round  = '0;
    for (int i = 0; i < LANES; i++) m_lfsr[i] = `LFSR_SEED_BASE + i;
    r1       = '0;
    r2       = '0;
    e_push   = 1'b0;
    e_phy    = 1'b0;
    e_dout   = '0;
    e_data   = '0;
    e_rounds = '0;
  endtask

  task automatic model_edge(input logic pull, input logic clr);
    lane_word_u w;
    if (clr) begin
      model_clear();   // in-flight periods are dropped
    end else begin
      e_push = r2.valid && (r2.phase != INIT);
      e_phy  = r2.valid && r2.phy;
      if (r2.valid) begin
        e_dout = r2.words;
        if (r2.phase == DATA_TRANSFER) e_data = e_data + 1;
        if (r2.phase == DELAY_ADJUST && r2.cnt == `ADJUST_LEN - 1) e_rounds = e_rounds + 1;
      end
      r2 = r1;
      r1 = '0;
      if (pull) begin
        r1.valid = 1'b1;
        r1.phase = m_phase;
        r1.cnt   = m_cnt;
        r1.phy   = (m_phase == DELAY_ADJUST) && (m_cnt > `PHY_LO) && (m_cnt < `PHY_HI);
        for (int i = 0; i < LANES; i++) begin
          w = '0;
          case (m_phase)
            DELAY_ADJUST:
              w.raw = (m_cnt > `PAT_LO && m_cnt < `PAT_HI) ? `ADJUST_PATTERN : 32'h0;
            WORD_ALIGN: begin
              w.align.code  = `ALIGN_CODE;
              w.align.lane  = 8'(i);
              w.align.round = m_round;
            end
            DATA_TRANSFER: begin
              w.raw     = m_lfsr[i];
              m_lfsr[i] = lfsr_step(m_lfsr[i]);
            end
            default: w = '0;
          endcase
          r1.words[32*i +: 32] = w.raw;
        end
        if (m_cnt == 0) begin
          case (m_phase)
            DELAY_ADJUST: begin
              m_phase = WORD_ALIGN;
              m_cnt   = 10'(`ALIGN_LEN - 1);
            end
            WORD_ALIGN: begin
              m_phase = DATA_TRANSFER;
              m_cnt   = 10'(`DATA_LEN - 1);
            end
            default: begin
              m_phase = DELAY_ADJUST;
              m_cnt   = 10'(`ADJUST_LEN - 1);
              m_round = m_round + 1;
            end
          endcase
        end else begin
          m_cnt = m_cnt - 1;
        end
      end
    end
  endtask

  // ####################################################################
  // stimulus
  // ####################################################################
  initial begin
    RSTX   = 1'b0;
    DOPULL = 1'b0;
    CLR    = 1'b0;
    rng    = 32'd83666;
    model_clear();
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RSTX = 1'b1;
    check_outputs();
    for (int r = 0; r < NROWS; r++) begin
      for (int c = 0; c < rows[r].cycles; c++) begin
        rng = xorshift(rng);
        if (c == 0 && rows[r].clr) begin
          CLR    = 1'b1;
          DOPULL = 1'b0;
        end else begin
          CLR    = 1'b0;
          DOPULL = (rng % 100) < rows[r].pct;
        end
        model_edge(DOPULL, CLR);
        @(negedge CLK);
        check_outputs();
      end
    end
    $display("sim passed");
    $finish;
  end

  // watchdog sized from the table plus reset and some slack
  initial begin
    int limit;
    limit = table_cycles() + 5 + 100;
    #(limit * 10);
    $display("timeout: the stimulus table did not complete in time");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== link_tx.f ====
+incdir+design
design/link_tx_pkg.sv
design/train_if.sv
design/train_sequencer.sv
design/lane_sender.sv
design/link_out_stage.sv
design/link_tx_top.sv
tb/tb_link_tx.sv

// ==== Bender.yml ====
package:
  name: link_tx

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/link_tx_pkg.sv
      - design/train_if.sv
      - design/train_sequencer.sv
      - design/lane_sender.sv
      - design/link_out_stage.sv
      - design/link_tx_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_link_tx.sv
